/* testbench/decode_patterns.hex */
// per packet: pc, lane 0 instr, lane 1 instr
// then one line per lane: ctrl, imm, rs1, rs2, rd
1000 123402B7 FFFF0317
484 12340000 8 3 5
38000604 FFFFFFFFFFFF0000 1E 1F 6
2000 FFF10093 40525193
28000620 FFFFFFFFFFFFFFFF 2 1F 1
16D450620 405 4 5 3
3000 409403B3 40C5D533
24000600 0 8 9 7
165450600 0 B C A
4000 FF87069B 411807BB
28200620 FFFFFFFFFFFFFFF8 E 18 D
24200600 0 10 11 F
5000 FF09B903 014AA623
E80B0520 FFFFFFFFFFFFFFF0 13 10 12
A802A010 C 15 14 C
6000 FE110EA3 FE418CE3
28008810 FFFFFFFFFFFFFFFD 2 1 1D
220000008 FFFFFFFFFFFFFFF8 3 4 19
7000 100000EF 007302B3
38100442 100 0 0 1
20000600 0 6 7 5
8000 FFC280E7 FF1FF06F
28100460 FFFFFFFFFFFFFFFC 5 1C 1
1F8170442 FFFFFFFFFFFFFFF0 1F 11 0
9000 00748493 00100073
28000620 7 9 7 9
1 0 0 1 0

/* filelist.f */
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/fetch_slicer.sv
design/instr_decoder.sv
design/decode_collector.sv
design/decode_stage_top.sv
testbench/decode_stage_checker.sv
testbench/decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module decode_stage_tb -o decode_stage_sim

./obj_dir/decode_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"

/* testbench/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

  localparam int lanes_n       = decode_ctrl_pkg::decode_lanes;
  localparam int n_pkt         = 9;
  localparam int n_extra       = 2;                 // sent after the ebreak packet
  localparam int words_per_pkt = 1 + 6 * lanes_n;   // pc, instrs, 5 expected words per lane
  localparam int ctrl_w        = $bits(decode_ctrl_pkg::decode_ctrl_t);

  logic                                                clk;
  logic                                                arst_n;
  logic                                                fetch_valid;
  decode_ctrl_pkg::fetch_pkt_t                         fetch_pkt;
  logic                                                dec_valid;
  decode_ctrl_pkg::lane_out_t [lanes_n-1:0]            dec_lanes;
  logic                                                halted;

  logic [63:0]          pat_mem [0:n_pkt*words_per_pkt-1];
  int                   exp_idx[$];
  int                   exp_due[$];
  logic [lanes_n-1:0]   exp_mask[$];
  int                   cyc;
  int                   err_cnt;
  integer               seed;

  decode_stage_top decode_stage_top_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pkt   (fetch_pkt),
    .dec_valid   (dec_valid),
    .dec_lanes   (dec_lanes),
    .halted      (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;  // edge counter for latency checks
  end

  task automatic stop_with_failure();
    err_cnt++;
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(string field);
    $display("ERR %0t %s mismatch", $time, field);
    stop_with_failure();
  endtask

  // squash rule applied to the expected control words
  function automatic logic [lanes_n-1:0] valid_mask(int idx);
    logic [lanes_n-1:0]            m;
    logic                          seen;
    decode_ctrl_pkg::decode_ctrl_t c;
    seen = 1'b0;
    for (int k = 0; k < lanes_n; k++) begin
      c    = pat_mem[idx*words_per_pkt + 1 + lanes_n + 5*k][ctrl_w-1:0];
      m[k] = !seen;
      seen = seen | c.jump_en | c.branch_en;
    end
    return m;
  endfunction

  // ========================================
  // stimulus
  // ========================================
  task automatic send_packets();
    int gap;
    int p;
    for (int n = 0; n < n_pkt + n_extra; n++) begin
      p = n % n_pkt;
      fetch_valid  = 1'b1;
      fetch_pkt.pc = pat_mem[p*words_per_pkt];
      for (int k = 0; k < lanes_n; k++) begin
        fetch_pkt.instr[k] = pat_mem[p*words_per_pkt + 1 + k][31:0];
      end
      if (n < n_pkt) begin
        exp_idx.push_back(p);
        exp_due.push_back(cyc + 2);
        exp_mask.push_back(valid_mask(p));
      end
      @(posedge clk);
      #10;
      fetch_valid = 1'b0;
      gap = $unsigned($random(seed)) % 3;  // 0 gives back to back
      repeat (gap) begin
        @(posedge clk);
        #10;
      end
    end
  endtask

  // ========================================
  // response checks
  // ========================================
  task automatic check_packet(int idx, int due, logic [lanes_n-1:0] mask);
    int                            w;
    decode_ctrl_pkg::decode_ctrl_t exp_ctrl;
    logic [63:0]                   exp_pc;
    assert (cyc == due) else report_mismatch("latency");
    for (int k = 0; k < lanes_n; k++) begin
      w        = idx*words_per_pkt + 1 + lanes_n + 5*k;
      exp_ctrl = pat_mem[w][ctrl_w-1:0];
      exp_pc   = pat_mem[idx*words_per_pkt] + 64'(4*k);
      assert (dec_lanes[k].valid == mask[k]) else report_mismatch($sformatf("lane %0d valid", k));
      assert (dec_lanes[k].pc == exp_pc) else report_mismatch($sformatf("lane %0d pc", k));
      assert (dec_lanes[k].ctrl == exp_ctrl) else report_mismatch($sformatf("lane %0d ctrl", k));
      assert (dec_lanes[k].imm == pat_mem[w+1]) else report_mismatch($sformatf("lane %0d imm", k));
      assert (dec_lanes[k].rs1 == pat_mem[w+2][4:0])
        else report_mismatch($sformatf("lane %0d rs1", k));
      assert (dec_lanes[k].rs2 == pat_mem[w+3][4:0])
        else report_mismatch($sformatf("lane %0d rs2", k));
      assert (dec_lanes[k].rd == pat_mem[w+4][4:0])
        else report_mismatch($sformatf("lane %0d rd", k));
    end
  endtask

  task automatic collect_packets();
    int waited;
    for (int n = 0; n < n_pkt; n++) begin
      waited = 0;
      @(negedge clk);
      while (!dec_valid) begin
        waited++;
        if (waited > 20) begin
          $display("no decoded packet arrived within 20 cycles");
          stop_with_failure();
        end
        @(negedge clk);
      end
      if (exp_idx.size() == 0) begin
        $display("a decoded packet arrived that was never sent");
        stop_with_failure();
      end
      check_packet(exp_idx.pop_front(), exp_due.pop_front(), exp_mask.pop_front());
    end
    // ebreak packet was the last one, so the stage stays quiet
    repeat (10) begin
      @(negedge clk);
      assert (!dec_valid) else report_mismatch("dec_valid after halt");
      assert (halted) else report_mismatch("halted");
    end
  endtask

  initial begin
    seed        = 41;
    err_cnt     = 0;
    arst_n      = 1'b0;
    fetch_valid = 1'b0;
    fetch_pkt   = '0;
    $readmemh("testbench/decode_patterns.hex", pat_mem);
    repeat (8) @(posedge clk);
    #10;
    arst_n = 1'b1;
    fork
      send_packets();
      collect_packets();
    join
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/decode_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_checker (
  input  logic                                                          clk,
  input  logic                                                          arst_n,
  input  logic                                                          fetch_valid,
  input  logic                                                          dec_valid,
  input  decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0] dec_lanes,
  input  logic                                                          halted
);

  // ========================================
  // stage timing and halt
  // ========================================
  a_latency : assert property (@(posedge clk) disable iff (!arst_n)
    $past(fetch_valid, 2) && !halted |-> dec_valid)
    else $error("dec_valid missing two cycles after fetch_valid");

  a_no_spurious : assert property (@(posedge clk) disable iff (!arst_n)
    dec_valid |-> $past(fetch_valid, 2))
    else $error("dec_valid without a packet");

  a_halt_sticky : assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted fell");

  a_quiet_halt : assert property (@(posedge clk) disable iff (!arst_n)
    !(dec_valid && halted))
    else $error("dec_valid while halted");

  for (genvar k = 0; k < decode_ctrl_pkg::decode_lanes; k++) begin : g_lane
    a_onehot : assert property (@(posedge clk) disable iff (!arst_n)
      dec_lanes[k].valid |-> $onehot0(dec_lanes[k].ctrl.store_len)
                             && $onehot0(dec_lanes[k].ctrl.wb_choose))
      else $error("store_len or wb_choose not one-hot");
  end

endmodule

bind decode_stage_top decode_stage_checker checker_inst (
  .clk         (clk),
  .arst_n      (arst_n),
  .fetch_valid (fetch_valid),
  .dec_valid   (dec_valid),
  .dec_lanes   (dec_lanes),
  .halted      (halted)
);

`default_nettype wire

/* design/decode_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_top (
  input  logic                                                          clk,
  input  logic                                                          arst_n,
  input  logic                                                          fetch_valid,
  input  decode_ctrl_pkg::fetch_pkt_t                                   fetch_pkt,
  output logic                                                          dec_valid,
  output decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0] dec_lanes,
  output logic                                                          halted
);

  decode_ctrl_pkg::lane_in_t  [decode_ctrl_pkg::decode_lanes-1:0] lane_in;
  decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0] lane_out;

  fetch_slicer fetch_slicer_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pkt   (fetch_pkt),
    .lanes       (lane_in)
  );

  // one combinational decoder per lane
  for (genvar i = 0; i < decode_ctrl_pkg::decode_lanes; i++) begin : g_lane
    instr_decoder instr_decoder_inst (
      .lane_in  (lane_in[i]),
      .lane_out (lane_out[i])
    );
  end

  decode_collector decode_collector_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .lanes     (lane_out),
    .dec_valid (dec_valid),
    .dec_lanes (dec_lanes),
    .halted    (halted)
  );

endmodule

`default_nettype wire

/* design/decode_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_collector (
  input  logic                                                          clk,
  input  logic                                                          arst_n,
  input  decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0] lanes,
  output logic                                                          dec_valid,
  output decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0] dec_lanes,
  output logic                                                          halted
);

  logic [decode_ctrl_pkg::decode_lanes-1:0]                             keep;
  logic [decode_ctrl_pkg::decode_lanes-1:0]                             vld_q;
  decode_ctrl_pkg::lane_out_t [decode_ctrl_pkg::decode_lanes-1:0]       lanes_q;
  logic                                                                 any_in;
  logic                                                                 ebreak_hit;
  logic                                                                 halt_next;

  // ========================================
  // squash after jump or branch
  // ========================================
  always_comb begin
    logic cf_seen;
    cf_seen = 1'b0;
    any_in  = 1'b0;
    for (int k = 0; k < decode_ctrl_pkg::decode_lanes; k++) begin
      keep[k] = lanes[k].valid & ~cf_seen;
      cf_seen = cf_seen | (keep[k] & (lanes[k].ctrl.jump_en | lanes[k].ctrl.branch_en));
      any_in  = any_in | lanes[k].valid;
    end
  end

  always_comb begin
    ebreak_hit = 1'b0;
    for (int k = 0; k < decode_ctrl_pkg::decode_lanes; k++) begin
      ebreak_hit = ebreak_hit | (vld_q[k] & lanes_q[k].ctrl.ebreak);  // delivered lanes only
    end
  end

  assign halt_next = halted | ebreak_hit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
      vld_q     <= '0;
      halted    <= 1'b0;
    end else begin
      dec_valid <= any_in & ~halt_next;
      vld_q     <= halt_next ? '0 : keep;
      halted    <= halt_next;  // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    lanes_q <= lanes;
  end

  always_comb begin
    dec_lanes = lanes_q;
    for (int k = 0; k < decode_ctrl_pkg::decode_lanes; k++) begin
      dec_lanes[k].valid = vld_q[k];
    end
  end

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  decode_ctrl_pkg::lane_in_t  lane_in,
  output decode_ctrl_pkg::lane_out_t lane_out
);

  rv_isa_pkg::instr_u            word;
  decode_ctrl_pkg::decode_ctrl_t ctrl;
  logic [rv_isa_pkg::xlen-1:0]   imm;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        op_11;
  logic        lui_en;
  logic        auipc_en;
  logic        jal_en;
  logic        jalr_en;
  logic        branch_en;
  logic        load_en;
  logic        store_en;
  logic        ioperate_en;
  logic        operate_en;
  logic        iwoperate_en;
  logic        woperate_en;
  logic        shift_en;
  logic [11:0] imm_i;
  logic [11:0] imm_s;
  logic [12:0] imm_b;
  logic [31:0] imm_u;
  logic [20:0] imm_j;

  assign word   = lane_in.instr;
  assign opcode = word.r.opcode;
  assign funct3 = word.r.funct3;
  assign funct7 = word.r.funct7;
  assign op_11  = (opcode[1:0] == 2'b11);  // 32-bit encoding

  // ========================================
  // class enables
  // ========================================
  assign lui_en       = op_11 & (opcode[6:2] == rv_isa_pkg::op_lui[6:2]);
  assign auipc_en     = op_11 & (opcode[6:2] == rv_isa_pkg::op_auipc[6:2]);
  assign jal_en       = op_11 & (opcode[6:2] == rv_isa_pkg::op_jal[6:2]);
  assign jalr_en      = op_11 & (opcode[6:2] == rv_isa_pkg::op_jalr[6:2]);
  assign branch_en    = op_11 & (opcode[6:2] == rv_isa_pkg::op_branch[6:2]);
  assign load_en      = op_11 & (opcode[6:2] == rv_isa_pkg::op_load[6:2]);
  assign store_en     = op_11 & (opcode[6:2] == rv_isa_pkg::op_store[6:2]);
  assign ioperate_en  = op_11 & (opcode[6:2] == rv_isa_pkg::op_op_imm[6:2]);
  assign operate_en   = op_11 & (opcode[6:2] == rv_isa_pkg::op_op[6:2]);
  assign iwoperate_en = op_11 & (opcode[6:2] == rv_isa_pkg::op_op_imm_32[6:2]);
  assign woperate_en  = op_11 & (opcode[6:2] == rv_isa_pkg::op_op_32[6:2]);

  assign shift_en     = (funct3[1:0] == 2'b01);  // slli/srli/srai and W forms

  // ========================================
  // control word
  // ========================================
  always_comb begin
    ctrl               = '0;
    ctrl.branch_en     = branch_en;
    ctrl.branch_opcode = funct3;
    ctrl.alu_en        = jal_en | jalr_en | branch_en | load_en | store_en | auipc_en
                       | ioperate_en | operate_en | iwoperate_en | woperate_en;
    ctrl.alu_pc_en     = auipc_en | jal_en;
    ctrl.alu_imm_en    = auipc_en | jal_en | jalr_en | load_en | store_en
                       | ioperate_en | iwoperate_en;
    if (ioperate_en | iwoperate_en) begin
      ctrl.alu_opcode = shift_en ? {funct7[5], 1'b0, funct3} : {2'b00, funct3};
    end else if (operate_en | woperate_en) begin
      ctrl.alu_opcode = {funct7[5], funct7[0], funct3};  // bit 5 picks sub/sra
    end else if (branch_en) begin
      ctrl.alu_opcode = {2'b00, funct3};
    end
    ctrl.alu_halfop    = iwoperate_en | woperate_en;
    ctrl.jump_en       = jal_en | jalr_en;
    ctrl.load_en       = load_en;
    ctrl.load_opcode   = funct3;
    ctrl.store_en      = store_en;
    if (store_en) begin
      ctrl.store_len = 4'b0001 << funct3[1:0];
    end
    ctrl.wb_en         = lui_en | auipc_en | jal_en | jalr_en | load_en
                       | ioperate_en | operate_en | iwoperate_en | woperate_en;
    ctrl.wb_choose[0]  = jal_en | jalr_en;  // pc + 4
    ctrl.wb_choose[1]  = lui_en;
    ctrl.wb_choose[2]  = load_en;
    ctrl.wb_choose[3]  = auipc_en | ioperate_en | operate_en | iwoperate_en | woperate_en;
    ctrl.i_type        = jalr_en | load_en | ioperate_en | iwoperate_en;
    ctrl.s_type        = store_en;
    ctrl.b_type        = branch_en;
    ctrl.u_type        = lui_en | auipc_en;
    ctrl.j_type        = jal_en;
    // imm 1, rs1 0, funct3 0, rd 0
    ctrl.ebreak        = (opcode == rv_isa_pkg::op_system) & (word.raw[31:7] == 25'h0002000);
  end

  // ========================================
  // immediate
  // ========================================
  assign imm_i = word.i.imm_11_0;
  assign imm_s = {word.s.imm_11_5, word.s.imm_4_0};
  assign imm_b = {word.b.imm_12, word.b.imm_11, word.b.imm_10_5, word.b.imm_4_1, 1'b0};
  assign imm_u = {word.u.imm_31_12, 12'h000};
  assign imm_j = {word.j.imm_20, word.j.imm_19_12, word.j.imm_11, word.j.imm_10_1, 1'b0};

  always_comb begin
    imm = '0;  // r-type and unknown
    if (ctrl.i_type) begin
      imm = {{(rv_isa_pkg::xlen-12){imm_i[11]}}, imm_i};
    end else if (ctrl.s_type) begin
      imm = {{(rv_isa_pkg::xlen-12){imm_s[11]}}, imm_s};
    end else if (ctrl.b_type) begin
      imm = {{(rv_isa_pkg::xlen-13){imm_b[12]}}, imm_b};
    end else if (ctrl.u_type) begin
      imm = {{(rv_isa_pkg::xlen-32){imm_u[31]}}, imm_u};
    end else if (ctrl.j_type) begin
      imm = {{(rv_isa_pkg::xlen-21){imm_j[20]}}, imm_j};
    end
  end

  assign lane_out = '{valid: lane_in.valid,
                      pc:    lane_in.pc,
                      ctrl:  ctrl,
                      imm:   imm,
                      rs1:   word.r.rs1,
                      rs2:   word.r.rs2,
                      rd:    word.r.rd};

endmodule

`default_nettype wire

/* design/fetch_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_slicer (
  input  logic                                                         clk,
  input  logic                                                         arst_n,
  input  logic                                                         fetch_valid,
  input  decode_ctrl_pkg::fetch_pkt_t                                  fetch_pkt,
  output decode_ctrl_pkg::lane_in_t [decode_ctrl_pkg::decode_lanes-1:0] lanes
);

  decode_ctrl_pkg::fetch_pkt_t pkt_q;
  logic                        vld_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      pkt_q <= fetch_pkt;  // hold last packet between strobes
    end
  end

  // ========================================
  // per-lane split
  // ========================================
  always_comb begin
    for (int i = 0; i < decode_ctrl_pkg::decode_lanes; i++) begin
      lanes[i].valid = vld_q;
      lanes[i].pc    = pkt_q.pc + (rv_isa_pkg::xlen)'(4 * i);  // 4 bytes per lane
      lanes[i].instr = pkt_q.instr[i];
    end
  end

endmodule

`default_nettype wire

/* design/decode_ctrl_pkg.sv */
`default_nettype none

package decode_ctrl_pkg;

  localparam int decode_lanes = 2;  // instructions per fetch packet
  localparam int wb_sel_w     = 4;

  // ========================================
  // decoded control word
  // ========================================
  typedef struct packed {
    logic                branch_en;
    logic [2:0]          branch_opcode;
    logic                alu_en;
    logic                alu_pc_en;      // operand a is pc
    logic                alu_imm_en;     // operand b is imm
    logic [4:0]          alu_opcode;
    logic                alu_halfop;     // 32-bit W form
    logic                jump_en;
    logic                load_en;
    logic [2:0]          load_opcode;
    logic                store_en;
    logic [3:0]          store_len;      // one-hot byte/half/word/double
    logic                wb_en;
    logic [wb_sel_w-1:0] wb_choose;      // one-hot link/imm/load/alu
    logic                i_type;
    logic                s_type;
    logic                b_type;
    logic                u_type;
    logic                j_type;
    logic                ebreak;
  } decode_ctrl_t;

  typedef struct packed {
    logic                         valid;
    logic [rv_isa_pkg::xlen-1:0]  pc;
    rv_isa_pkg::instr_u           instr;
  } lane_in_t;

  typedef struct packed {
    logic                         valid;
    logic [rv_isa_pkg::xlen-1:0]  pc;
    decode_ctrl_t                 ctrl;
    logic [rv_isa_pkg::xlen-1:0]  imm;
    logic [4:0]                   rs1;
    logic [4:0]                   rs2;
    logic [4:0]                   rd;
  } lane_out_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0]     pc;     // pc of lane 0
    logic [decode_lanes-1:0][31:0]   instr;
  } fetch_pkt_t;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 64;

  // ========================================
  // major opcodes
  // ========================================
  localparam logic [6:0] op_lui       = 7'b0110111;
  localparam logic [6:0] op_auipc     = 7'b0010111;
  localparam logic [6:0] op_jal       = 7'b1101111;
  localparam logic [6:0] op_jalr      = 7'b1100111;
  localparam logic [6:0] op_branch    = 7'b1100011;
  localparam logic [6:0] op_load      = 7'b0000011;
  localparam logic [6:0] op_store     = 7'b0100011;
  localparam logic [6:0] op_op_imm    = 7'b0010011;
  localparam logic [6:0] op_op        = 7'b0110011;
  localparam logic [6:0] op_op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_op_32     = 7'b0111011;
  localparam logic [6:0] op_system    = 7'b1110011;

  // ========================================
  // instruction formats, msb first
  // ========================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
  } instr_u;

endpackage

`default_nettype wire
